//--- common/dma_req_pkg.sv
// Shared constants of the DMA read-request path
// Request sizes are in bytes, so word counts drop the two low bits
// Only incrementing bursts and cycle termination are used on the bus

package dma_req_pkg;

  //////////////////////////////////////////////////
  // Request size
  //////////////////////////////////////////////////

  // Width of the size field of a request in bytes
  localparam int size_width = 14;

  // Word counts and word-based sizes
  typedef logic [size_width-3:0] req_size_t;

  //////////////////////////////////////////////////
  // Bus burst codes
  //////////////////////////////////////////////////

  // Incrementing burst of unspecified length
  localparam logic [2:0] burst_incr = 3'b010;

  // Cycle termination, the current beat is the final one
  localparam logic [2:0] burst_last = 3'b111;

  //////////////////////////////////////////////////
  // Read FIFO
  //////////////////////////////////////////////////

  // One decoupling slot, one for the stream-side delay of back-pressure,
  // one for the word still in flight during burst termination
  localparam int fifo_depth = 3;

endpackage

//--- common/word_count_if.sv
// Link between the fetch FSM and the word counter
// clear and advance act at the next clock edge
// last is combinational from the count and the request size

`timescale 1ns/100ps

interface word_count_if;
  import dma_req_pkg::*;

  // FSM to counter
  logic clear;
  logic advance;

  // Counter state and last-word flag
  req_size_t count;
  logic      last;

  // FSM side only needs the last-word flag
  modport fsm (output clear, output advance, input last);

  // Counter side owns the count
  modport counter (input clear, input advance, output count, output last);

endinterface

//--- dma_req.f
common/dma_req_pkg.sv
common/word_count_if.sv
initiator/req_fetch_fsm.sv
initiator/word_counter.sv
initiator/read_fifo.sv
verilog/dma_req_top.sv
test/dma_req_asserts.sv
test/dma_req_tb.sv

//--- initiator/read_fifo.sv
// Three-entry shifting FIFO between the bus and the word stream
// Output comes straight from the head register, no input-to-output path
// fill_ok drops at two entries, leaving one slot for the word in flight
// Pop on an empty FIFO has no effect

`timescale 1ns/100ps

module read_fifo #(
  parameter int data_width = 32
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  push,
  input  logic [data_width-1:0] push_data,
  input  logic                  pop,
  output logic                  fill_ok,
  output logic                  valid,
  output logic [data_width-1:0] head
);
  import dma_req_pkg::*;

  // Storage, slot 0 is the head
  logic [data_width-1:0] slot [fifo_depth];

  // Word each slot takes on a shift
  logic [data_width-1:0] shift_in [fifo_depth];

  // One-hot write position, bit 0 set means empty, top bit means full
  logic [fifo_depth:0] pos;

  // Effective pop, only when a word is present
  logic do_pop;

  assign valid   = ~pos[0];
  assign head    = slot[0];
  assign do_pop  = pop & valid;

  // High-water mark
  assign fill_ok = ~|pos[fifo_depth:2];

  //////////////////////////////////////////////////
  // Position register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      pos <= {{fifo_depth{1'b0}}, 1'b1};
    end else if (push & ~do_pop) begin
      pos <= pos << 1;
    end else if (do_pop & ~push) begin
      pos <= pos >> 1;
    end
  end

  //////////////////////////////////////////////////
  // Data shifting
  //////////////////////////////////////////////////

  // Top slot keeps its word on a shift
  for (genvar i = 0; i < fifo_depth; i++) begin : g_shift
    if (i < fifo_depth - 1) begin : g_mid
      assign shift_in[i] = slot[i+1];
    end else begin : g_top
      assign shift_in[i] = slot[i];
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < fifo_depth; i++) begin
      if (do_pop) begin
        // Pushed word lands in the slot freed by the pop
        if (push & pos[i+1]) begin
          slot[i] <= push_data;
        end else begin
          slot[i] <= shift_in[i];
        end
      end else if (push & pos[i]) begin
        slot[i] <= push_data;
      end
    end
  end

endmodule

//--- initiator/req_fetch_fsm.sv
// Bus-side sequencer of the read burst
// Only local-to-remote requests are fetched; other starts are ignored
// No error, split or retry responses are handled
// hsel, hmastlock and push come straight from the state

`timescale 1ns/100ps

module req_fetch_fsm #(
  parameter int addr_width = 32
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       req_start,
  input  logic       req_is_l2r,
  input  logic       hready,
  input  logic       fill_ok,
  output logic       hsel,
  output logic       hmastlock,
  output logic [2:0] hburst,
  output logic       push,
  word_count_if.fsm  cnt
);
  import dma_req_pkg::*;

  //////////////////////////////////////////////////
  // State encoding
  //////////////////////////////////////////////////

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_data = 2'd1;
  localparam logic [1:0] st_wait = 2'd2;

  logic [1:0] state;
  logic [1:0] state_nxt;

  // Byte offset of the largest request must fit in the address
  if (addr_width < size_width) begin : g_addr_check
    $error("addr_width is narrower than the request byte offset");
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  // Select and lock together, no wait states are inserted by the master
  assign hsel      = (state == st_data);
  assign hmastlock = hsel;

  // A completing beat goes to the FIFO and moves the count on
  assign push        = hsel & hready;
  assign cnt.advance = push;

  // Count restarts from zero for every request
  assign cnt.clear = (state == st_idle);

  // Terminate the burst on the last word or when the FIFO
  // cannot take the word after this one
  assign hburst = (hsel & (~fill_ok | cnt.last)) ? burst_last : burst_incr;

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        // FIFO is always empty here, go straight to the bus
        if (req_start & req_is_l2r) begin
          state_nxt = st_data;
        end
      end
      st_data: begin
        // Stay in data until the slave completes the beat
        if (hready) begin
          if (cnt.last) begin
            state_nxt = st_idle;
          end else if (~fill_ok) begin
            state_nxt = st_wait;
          end
        end
      end
      st_wait: begin
        // Restart the burst once the FIFO drains below high water
        if (fill_ok) begin
          state_nxt = st_data;
        end
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

endmodule

//--- initiator/word_counter.sv
// Word counter and address generator of the read burst
// req_size and req_laddr must stay stable for the whole request
// A size of zero is not supported

`timescale 1ns/100ps

module word_counter #(
  parameter int addr_width = 32
) (
  input  logic                    clk,
  input  logic                    rst,
  input  dma_req_pkg::req_size_t  req_size,
  input  logic [addr_width-1:0]   req_laddr,
  output logic [addr_width-1:0]   haddr,
  word_count_if.counter           cnt
);
  import dma_req_pkg::*;

  // Index of the final word of the request
  req_size_t size_m1;

  // Byte offset of the current word from the base
  logic [addr_width-1:0] byte_offset;

  assign size_m1 = req_size - 1'b1;

  // Flag the last word of the run
  assign cnt.last = (cnt.count == size_m1);

  // Count is in words, the bus wants bytes
  assign byte_offset = addr_width'({cnt.count, 2'b00});
  assign haddr       = req_laddr + byte_offset;

  //////////////////////////////////////////////////
  // Count register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt.count <= '0;
    end else if (cnt.clear) begin
      cnt.count <= '0;
    end else if (cnt.advance) begin
      cnt.count <= cnt.count + 1'b1;
    end
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the DMA read-request testbench with Verilator and runs it.
# The run passes only if the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal --top-module dma_req_tb \
  -f dma_req.f -o dma_req_sim > build.log 2>&1 \
  && ./obj_dir/dma_req_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Simulation build or run failed"; exit 1; }

cat sim.log

grep -q "^NO ERRORS$" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- test/dma_req_asserts.sv
// Concurrent checks on the bus side of the DMA read-request path
// Bound to dma_req_top, pos is the one-hot position register of the FIFO
// Checks are disabled while rst is high, except the post-reset check

`timescale 1ns/100ps

module dma_req_asserts #(
  parameter int addr_width = 32
) (
  input logic                           clk,
  input logic                           rst,
  input logic                           hsel,
  input logic [addr_width-1:0]          haddr,
  input logic [2:0]                     hburst,
  input logic                           hmastlock,
  input logic                           hready,
  input logic [dma_req_pkg::fifo_depth:0] pos
);
  import dma_req_pkg::*;

  //////////////////////////////////////////////////
  // Bus port
  //////////////////////////////////////////////////

  // Word transfers only
  a_haddr_aligned: assert property (@(posedge clk) disable iff (rst)
    hsel |-> (haddr[1:0] == 2'b00))
    else $error("haddr not word-aligned while hsel is high");

  // Lock is held for exactly the selected cycles
  a_lock_follows_sel: assert property (@(posedge clk) disable iff (rst)
    hmastlock == hsel)
    else $error("hmastlock differs from hsel");

  // A completing beat with cycle termination ends the burst
  a_term_drops_sel: assert property (@(posedge clk) disable iff (rst)
    (hsel && hready && (hburst == burst_last)) |=> !hsel)
    else $error("hsel still high after a terminating beat");

  // First cycle out of reset
  a_sel_low_after_reset: assert property (@(posedge clk)
    $fell(rst) |-> !hsel)
    else $error("hsel high in the cycle after reset");

  //////////////////////////////////////////////////
  // FIFO occupancy
  //////////////////////////////////////////////////

  // One-hot over fifo_depth+1 bits, so occupancy stays within fifo_depth
  a_fifo_bound: assert property (@(posedge clk) disable iff (rst)
    $onehot(pos))
    else $error("FIFO position register left its range");

endmodule

//--- test/dma_req_tb.sv
// Testbench of the DMA read-request path
// Memory slave answers in the same cycle with the address XOR a constant
// req_size counts words, every request base is word-aligned

`timescale 1ns/100ps

module dma_req_tb;
  import dma_req_pkg::*;

  localparam int addr_width  = 32;
  localparam int data_width  = 32;
  localparam int num_req     = 8;
  localparam int req_timeout = 4000;
  localparam int quiet_len   = 40;

  //////////////////////////////////////////////////
  // Request table
  //////////////////////////////////////////////////

  // Base, size in words, l2r flag, sink ready rate in %, stall window
  // A nonzero stall window alternates 0 % and 100 % ready
  localparam logic [31:0] tbl_base [num_req] = '{
    32'h0000_1000, 32'h0000_2040, 32'h0000_3000, 32'h0001_0000,
    32'h0000_4ffc, 32'h8000_0100, 32'h0000_0200, 32'h00ff_fff0};
  localparam int tbl_size [num_req]  = '{8, 1, 16, 24, 12, 5, 1, 40};
  localparam bit tbl_l2r [num_req]   = '{1, 1, 0, 1, 1, 1, 1, 1};
  localparam int tbl_rate [num_req]  = '{100, 50, 100, 0, 30, 100, 0, 70};
  localparam int tbl_stall [num_req] = '{0, 0, 0, 60, 0, 0, 25, 0};

  logic                  clk;
  logic                  rst;
  logic                  hsel;
  logic [addr_width-1:0] haddr;
  logic [2:0]            hburst;
  logic                  hmastlock;
  logic [data_width-1:0] hrdata;
  logic                  hready;
  logic                  req_start;
  logic                  req_is_l2r;
  req_size_t             req_size;
  logic [addr_width-1:0] req_laddr;
  logic                  req_data_valid;
  logic [data_width-1:0] req_data;
  logic                  req_data_ready;

  dma_req_top #(.addr_width(addr_width), .data_width(data_width)) uut (.*);

  bind dma_req_top dma_req_asserts #(.addr_width(addr_width)) u_asserts (
    .clk       (clk),
    .rst       (rst),
    .hsel      (hsel),
    .haddr     (haddr),
    .hburst    (hburst),
    .hmastlock (hmastlock),
    .hready    (hready),
    .pos       (u_fifo.pos)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Memory slave model
  //////////////////////////////////////////////////

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return addr ^ 32'h5a3c_96e1;
  endfunction

  assign hrdata = mem_word(haddr);

  // Random wait states, about 70 % ready
  initial begin
    hready = 1'b0;
    forever begin
      @(posedge clk);
      hready <= ($urandom_range(99) < 70);
    end
  end

  //////////////////////////////////////////////////
  // Checking helpers
  //////////////////////////////////////////////////

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string msg);
    if (actual !== expected) begin
      $display("Fail at %0t: %s (got %h, expected %h)", $time, msg, actual, expected);
      $display("ERRORS FOUND");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic report_stall(input string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("ERRORS FOUND");
    $fatal(1, "Wait loop timed out");
  endtask

  // Sink ready for one cycle
  function automatic logic sink_ready(input int rate, input int stall, input int cycle);
    if (stall > 0) begin
      return (cycle % (2 * stall)) >= stall;
    end
    return ($urandom_range(99) < rate);
  endfunction

  // Final word, or two words already waiting in the FIFO, ends the burst
  function automatic logic [2:0] expected_burst(input int fetched, input int streamed,
                                                input int size);
    if ((fetched == size - 1) || (fetched - streamed >= 2)) begin
      return burst_last;
    end
    return burst_incr;
  endfunction

  // Bus and stream must stay silent for n cycles
  task automatic expect_quiet(input int n, input string why);
    for (int c = 0; c < n; c++) begin
      @(posedge clk);
      check_equal(32'(hsel), 32'd0, {"hsel high ", why});
      check_equal(32'(req_data_valid), 32'd0, {"req_data_valid high ", why});
      req_data_ready <= 1'b1;
    end
  endtask

  //////////////////////////////////////////////////
  // One request from the table
  //////////////////////////////////////////////////

  task automatic run_request(input int idx);
    logic [31:0] base;
    int          size;
    int          got;
    int          done_bus;
    int          cycles;

    base     = tbl_base[idx];
    size     = tbl_size[idx];
    got      = 0;
    done_bus = 0;
    cycles   = 0;

    @(posedge clk);
    req_laddr  <= base;
    req_size   <= req_size_t'(size);
    req_is_l2r <= tbl_l2r[idx];
    req_start  <= 1'b1;
    @(posedge clk);
    req_start  <= 1'b0;

    if (!tbl_l2r[idx]) begin
      expect_quiet(quiet_len, "for an ignored request");
      return;
    end

    while (got < size) begin
      @(posedge clk);
      cycles++;
      if (cycles > req_timeout) begin
        report_stall($sformatf("request %0d stuck after %0d of %0d words", idx, got, size));
      end
      if (cycles == 1) begin
        check_equal(32'(hsel), 32'd1, "hsel one cycle after start");
      end
      check_equal(32'(hmastlock), 32'(hsel), "hmastlock follows hsel");

      // Bus side, hsel must stay low once every word is fetched
      if (done_bus == size) begin
        check_equal(32'(hsel), 32'd0, "hsel after the last bus completion");
      end
      // FIFO occupancy is completions minus pops seen so far
      if (hsel) begin
        check_equal(32'(hburst), 32'(expected_burst(done_bus, got, size)),
                    "hburst on a data cycle");
      end
      if (hsel && hready) begin
        check_equal(haddr, base + 32'(4 * done_bus), "haddr of a completing beat");
        done_bus++;
      end

      // Stream side
      if (req_data_valid && req_data_ready) begin
        check_equal(req_data, mem_word(base + 32'(4 * got)), "streamed word");
        got++;
      end
      req_data_ready <= sink_ready(tbl_rate[idx], tbl_stall[idx], cycles);
    end

    check_equal(32'(done_bus), 32'(size), "bus completions per request");
    expect_quiet(8, "after the last word");
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(32'hd2cb_28ea));
    rst            = 1'b1;
    req_start      = 1'b0;
    req_is_l2r     = 1'b0;
    req_size       = '0;
    req_laddr      = '0;
    req_data_ready = 1'b0;

    repeat (10) @(posedge clk);
    rst <= 1'b0;

    // Idle outputs out of reset
    @(posedge clk);
    check_equal(32'(hsel), 32'd0, "hsel after reset");
    check_equal(32'(req_data_valid), 32'd0, "req_data_valid after reset");
    check_equal(32'(hburst), 32'(burst_incr), "hburst after reset");

    for (int i = 0; i < num_req; i++) begin
      run_request(i);
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- verilog/dma_req_top.sv
// Read-request side of the DMA initiator
// Constant bus outputs (hwdata, hwrite, hprot, htrans) are tied off outside
// req_laddr and req_size must hold until the last word has been streamed

`timescale 1ns/100ps

module dma_req_top #(
  parameter int addr_width = 32,
  parameter int data_width = 32
) (
  input  logic                   clk,
  input  logic                   rst,

  // Bus read master
  output logic                   hsel,
  output logic [addr_width-1:0]  haddr,
  output logic [2:0]             hburst,
  output logic                   hmastlock,
  input  logic [data_width-1:0]  hrdata,
  input  logic                   hready,

  // Request and word stream
  input  logic                   req_start,
  input  logic                   req_is_l2r,
  input  dma_req_pkg::req_size_t req_size,
  input  logic [addr_width-1:0]  req_laddr,
  output logic                   req_data_valid,
  output logic [data_width-1:0]  req_data,
  input  logic                   req_data_ready
);

  //////////////////////////////////////////////////
  // Internal links
  //////////////////////////////////////////////////

  // FSM to counter
  word_count_if cnt ();

  // FSM to FIFO
  logic push;
  logic fill_ok;

  //////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////

  req_fetch_fsm #(.addr_width(addr_width)) u_fsm (
    .clk        (clk),
    .rst        (rst),
    .req_start  (req_start),
    .req_is_l2r (req_is_l2r),
    .hready     (hready),
    .fill_ok    (fill_ok),
    .hsel       (hsel),
    .hmastlock  (hmastlock),
    .hburst     (hburst),
    .push       (push),
    .cnt        (cnt.fsm)
  );

  word_counter #(.addr_width(addr_width)) u_counter (
    .clk       (clk),
    .rst       (rst),
    .req_size  (req_size),
    .req_laddr (req_laddr),
    .haddr     (haddr),
    .cnt       (cnt.counter)
  );

  // Read data goes straight into the FIFO, the sink ready is the pop
  read_fifo #(.data_width(data_width)) u_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (push),
    .push_data (hrdata),
    .pop       (req_data_ready),
    .fill_ok   (fill_ok),
    .valid     (req_data_valid),
    .head      (req_data)
  );

endmodule
